//--- ooo_issue.f
logic/ooo_pkg.sv
logic/cdb_if.sv
logic/issue_if.sv
logic/reservation_station.sv
logic/alu_pipe.sv
logic/ls_pipe.sv
logic/cdb_arbiter.sv
logic/ooo_issue_top.sv
verif/tb_clock.sv
verif/ooo_issue_assert.sv
verif/ooo_issue_tb.sv

//--- Makefile
TOP = ooo_issue_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f ooo_issue.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f ooo_issue.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- verif/ooo_issue_tb.sv
`timescale 1ns/1ps

module ooo_issue_tb;

  localparam int LIMIT = 400 * (ooo_pkg::ALU_LATENCY + ooo_pkg::LS_LATENCY);

  logic clk, rst, flush;
  logic alu_dispatch, alu_src2_imm, ls_dispatch;
  logic ls_mem_read, ls_mem_write, ls_mem_to_reg;
  logic [1:0] alu_src_ready, ls_src_ready;
  logic [3:0] alu_op;
  logic [2:0] ls_funct3;
  logic [31:0] alu_imm, ls_imm;
  ooo_pkg::inst_num_t alu_inst_num, ls_inst_num, cdb_inst_num, store_inst_num;
  ooo_pkg::tag_t alu_dest, alu_src1, alu_src2, ls_dest, ls_src1, ls_src2, cdb_tag;
  logic alu_full, ls_full, cdb_valid, store_done;

  // scoreboard indexed by inst_num
  ooo_pkg::tag_t dest_a[256], src1_a[256], src2_a[256];
  bit is_store[256], done[256], cancelled[256];
  // tags broadcast so far, or given as ready at dispatch
  bit seen[256];
  ooo_pkg::tag_t pool[$];
  int n_sent, n_done, n_cancel;
  bit passed, reported;
  logic [31:0] lfsr;

  tb_clock clk_gen (.clk(clk), .rst(rst));

  ooo_issue_top uut (.*);

  // ========================================
  // helpers
  // ========================================

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // legal only once both sources were broadcast or ready at dispatch
  function automatic bit expected_legal(input int k);
    return seen[src1_a[k]] && seen[src2_a[k]];
  endfunction

  task automatic fail_run(input string msg);
    reported = 1'b1;
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopped on first error");
  endtask

  task automatic idle();
    @(posedge clk);
    alu_dispatch <= 1'b0;
    ls_dispatch  <= 1'b0;
  endtask

  task automatic send(input bit st, input ooo_pkg::tag_t s1, input ooo_pkg::tag_t s2,
                      input logic [1:0] rdy, input bit store);
    int k;
    ooo_pkg::tag_t d;
    logic [1:0] ready;
    @(posedge clk);
    // a source broadcast before this edge is ready at dispatch
    ready = rdy;
    if (seen[s1]) ready[0] = 1'b1;
    if (seen[s2]) ready[1] = 1'b1;
    k = n_sent;
    d = 8'(16 + k);
    dest_a[k] = d;
    src1_a[k] = s1;
    src2_a[k] = s2;
    is_store[k] = store;
    if (ready[0]) seen[s1] = 1'b1;
    if (ready[1]) seen[s2] = 1'b1;
    if (!store) pool.push_back(d);
    alu_dispatch <= !st;
    ls_dispatch <= st;
    alu_inst_num <= 32'(k);
    ls_inst_num <= 32'(k);
    alu_dest <= d;
    ls_dest <= d;
    alu_src1 <= s1;
    ls_src1 <= s1;
    alu_src2 <= s2;
    ls_src2 <= s2;
    alu_src_ready <= ready;
    ls_src_ready <= ready;
    alu_op <= 4'(take_bits(4));
    alu_src2_imm <= 1'(take_bits(1));
    alu_imm <= 32'(k);
    ls_mem_read <= !store;
    ls_mem_write <= store;
    ls_mem_to_reg <= !store;
    ls_funct3 <= 3'(take_bits(3));
    ls_imm <= 32'(k);
    n_sent++;
  endtask

  task automatic pick_src(output ooo_pkg::tag_t t, output bit r);
    if (pool.size() > 0 && take_bits(1) == 1) begin
      t = pool[take_bits(6) % pool.size()];
    end else begin
      t = 8'hF0 | 8'(take_bits(4));
    end
    // tags in the top range have no producer and are always ready
    r = (t >= 8'hF0) || (take_bits(1) == 1);
  endtask

  task automatic wait_not_full(input bit st);
    int t;
    t = 0;
    forever begin
      @(negedge clk);
      if (!(st ? ls_full : alu_full)) break;
      t++;
      if (t > LIMIT) fail_run("timed out waiting for a free station entry");
    end
  endtask

  task automatic wait_outstanding(input int left);
    int t;
    t = 0;
    while (n_sent - n_done - n_cancel > left) begin
      @(posedge clk);
      t++;
      if (t > LIMIT) fail_run("timed out waiting for instructions to complete");
    end
  endtask

  // ========================================
  // comparing process
  // ========================================

  task automatic check_cycle();
    int k;
    if (n_sent == 0) begin
      assert (!cdb_valid && !store_done && !alu_full && !ls_full)
        else fail_run($sformatf("ERR %0t: output active before first dispatch", $time));
    end
    if (cdb_valid) begin
      k = int'(cdb_inst_num[7:0]);
      assert (cdb_inst_num < n_sent && !is_store[k] && !done[k] && !cancelled[k])
        else fail_run($sformatf("ERR %0t: unexpected cdb inst %0d", $time, cdb_inst_num));
      assert (cdb_tag == dest_a[k])
        else fail_run($sformatf("ERR %0t: inst %0d tag %h, expected %h", $time, k, cdb_tag,
                                dest_a[k]));
      assert (expected_legal(k))
        else fail_run($sformatf("ERR %0t: inst %0d completed before its sources", $time, k));
      done[k] = 1'b1;
      n_done++;
    end
    if (store_done) begin
      k = int'(store_inst_num[7:0]);
      assert (store_inst_num < n_sent && is_store[k] && !done[k] && !cancelled[k])
        else fail_run($sformatf("ERR %0t: unexpected store %0d", $time, store_inst_num));
      assert (expected_legal(k))
        else fail_run($sformatf("ERR %0t: store %0d done before its sources", $time, k));
      done[k] = 1'b1;
      n_done++;
    end
    if (cdb_valid) seen[cdb_tag] = 1'b1;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (!rst) check_cycle();
    end
  end

  // ========================================
  // stimulus
  // ========================================

  initial begin
    int t, p;
    bit st;
    ooo_pkg::tag_t s1, s2;
    bit r1, r2;
    flush = 1'b0;
    alu_dispatch = 1'b0;
    ls_dispatch = 1'b0;
    {alu_inst_num, alu_dest, alu_src1, alu_src2, alu_src_ready} = '0;
    {alu_op, alu_src2_imm, alu_imm} = '0;
    {ls_inst_num, ls_dest, ls_src1, ls_src2, ls_src_ready} = '0;
    {ls_mem_read, ls_mem_write, ls_mem_to_reg, ls_funct3, ls_imm} = '0;
    lfsr = 32'h3430_00a9;
    t = 0;
    while (rst !== 1'b0) begin
      @(posedge clk);
      t++;
      if (t > 20) fail_run("reset never released");
    end
    repeat (5) idle();

    // consumer dispatched while its producer is on the cdb
    p = n_sent;
    send(1'b0, 8'hF1, 8'hF2, 2'b11, 1'b0);
    idle();
    idle();
    send(1'b1, dest_a[p], 8'hF3, 2'b10, 1'b0);
    @(negedge clk);
    assert (cdb_valid && cdb_tag == dest_a[p])
      else fail_run($sformatf("ERR %0t: producer not on cdb at dispatch", $time));
    idle();
    wait_outstanding(0);

    repeat (60) begin
      st = 1'(take_bits(1));
      wait_not_full(st);
      pick_src(s1, r1);
      pick_src(s2, r2);
      send(st, s1, s2, {r2, r1}, st && (take_bits(1) == 1));
      idle();
    end
    wait_outstanding(0);

    // park eight ALU ops on a tag that is never broadcast
    repeat (8) begin
      send(1'b0, 8'hEE, 8'hF4, 2'b10, 1'b0);
      idle();
    end
    @(negedge clk);
    assert (alu_full && !ls_full)
      else fail_run($sformatf("ERR %0t: alu_full %b ls_full %b", $time, alu_full, ls_full));
    repeat (4) begin
      send(1'b1, 8'hF5, 8'hF6, 2'b11, take_bits(1) == 1);
      idle();
    end
    wait_outstanding(8);

    // this load is still in the load/store pipe when the flush arrives
    send(1'b1, 8'hF5, 8'hF6, 2'b11, 1'b0);
    idle();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    // whatever has not completed by this edge was cancelled by the flush
    for (int i = 0; i < n_sent; i++) begin
      if (!done[i]) begin
        cancelled[i] = 1'b1;
        n_cancel++;
      end
    end
    @(negedge clk);
    assert (!alu_full && !ls_full)
      else fail_run($sformatf("ERR %0t: full still high after flush", $time));
    repeat (20) idle();

    repeat (6) begin
      st = 1'(take_bits(1));
      send(st, 8'hF7, 8'hF8, 2'b11, st && (take_bits(1) == 1));
      idle();
    end
    wait_outstanding(0);

    passed = 1'b1;
    $display("All checks passed");
    $finish;
  end

  // a bound assertion may end the run early
  final begin
    if (!passed && !reported) begin
      $display("Checks failed");
    end
  end

endmodule

//--- verif/ooo_issue_assert.sv
`timescale 1ns/1ps

module ooo_issue_assert (
  input logic clk,
  input logic rst,
  input logic flush,
  input logic grant_a,
  input logic grant_b,
  input logic cdb_valid,
  input logic fire,
  input logic accept
);

  // the shared bus takes one result per cycle
  one_grant: assert property (@(posedge clk) disable iff (rst) !(grant_a && grant_b))
    else $error("both pipes granted in one cycle");

  fire_needs_accept: assert property (@(posedge clk) disable iff (rst) fire |-> accept)
    else $error("issue fired while the pipe did not accept");

  quiet_after_clear: assert property (@(posedge clk) (rst || flush) |=> !cdb_valid)
    else $error("cdb valid in the cycle after reset or flush");

endmodule

bind cdb_arbiter ooo_issue_assert arb_chk (
  .clk(clk), .rst(rst), .flush(flush),
  .grant_a(alu_grant), .grant_b(ls_grant), .cdb_valid(cdb.valid),
  .fire(1'b0), .accept(1'b0)
);

bind reservation_station ooo_issue_assert rs_chk (
  .clk(clk), .rst(rst), .flush(flush),
  .grant_a(1'b0), .grant_b(1'b0), .cdb_valid(cdb.valid),
  .fire(issue.fire), .accept(issue.accept)
);

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- logic/ooo_issue_top.sv
`timescale 1ns/1ps

module ooo_issue_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  logic               alu_dispatch,
  input  ooo_pkg::inst_num_t alu_inst_num,
  input  ooo_pkg::tag_t      alu_dest,
  input  ooo_pkg::tag_t      alu_src1,
  input  ooo_pkg::tag_t      alu_src2,
  input  logic [1:0]         alu_src_ready,
  input  logic [3:0]         alu_op,
  input  logic               alu_src2_imm,
  input  logic [31:0]        alu_imm,
  input  logic               ls_dispatch,
  input  ooo_pkg::inst_num_t ls_inst_num,
  input  ooo_pkg::tag_t      ls_dest,
  input  ooo_pkg::tag_t      ls_src1,
  input  ooo_pkg::tag_t      ls_src2,
  input  logic [1:0]         ls_src_ready,
  input  logic               ls_mem_read,
  input  logic               ls_mem_write,
  input  logic               ls_mem_to_reg,
  input  logic [2:0]         ls_funct3,
  input  logic [31:0]        ls_imm,
  output logic               alu_full,
  output logic               ls_full,
  output logic               cdb_valid,
  output ooo_pkg::tag_t      cdb_tag,
  output ooo_pkg::inst_num_t cdb_inst_num,
  output logic               store_done,
  output ooo_pkg::inst_num_t store_inst_num
);

  ooo_pkg::alu_payload_t alu_payload;
  ooo_pkg::ls_payload_t  ls_payload;

  logic               alu_req;
  ooo_pkg::tag_t      alu_req_tag;
  ooo_pkg::inst_num_t alu_req_inst_num;
  logic               alu_grant;
  logic               ls_req;
  ooo_pkg::tag_t      ls_req_tag;
  ooo_pkg::inst_num_t ls_req_inst_num;
  logic               ls_grant;

  cdb_if                                        cdb_bus ();
  issue_if #(.payload_t(ooo_pkg::alu_payload_t)) alu_issue ();
  issue_if #(.payload_t(ooo_pkg::ls_payload_t))  ls_issue ();

  assign alu_payload.alu_op    = alu_op;
  assign alu_payload.alu_src2  = alu_src2_imm;
  assign alu_payload.immediate = alu_imm;

  assign ls_payload.mem_read   = ls_mem_read;
  assign ls_payload.mem_write  = ls_mem_write;
  assign ls_payload.mem_to_reg = ls_mem_to_reg;
  assign ls_payload.funct3     = ls_funct3;
  assign ls_payload.immediate  = ls_imm;

  // ========================================
  // stations
  // ========================================

  reservation_station #(.payload_t(ooo_pkg::alu_payload_t)) alu_rs (
    .clk(clk), .rst(rst), .flush(flush),
    .dispatch(alu_dispatch), .dispatch_inst_num(alu_inst_num),
    .dispatch_dest(alu_dest), .src1(alu_src1), .src2(alu_src2),
    .src_ready(alu_src_ready), .dispatch_payload(alu_payload),
    .full(alu_full), .cdb(cdb_bus.sink), .issue(alu_issue.source)
  );

  reservation_station #(.payload_t(ooo_pkg::ls_payload_t)) ls_rs (
    .clk(clk), .rst(rst), .flush(flush),
    .dispatch(ls_dispatch), .dispatch_inst_num(ls_inst_num),
    .dispatch_dest(ls_dest), .src1(ls_src1), .src2(ls_src2),
    .src_ready(ls_src_ready), .dispatch_payload(ls_payload),
    .full(ls_full), .cdb(cdb_bus.sink), .issue(ls_issue.source)
  );

  // ========================================
  // pipes and the shared bus
  // ========================================

  alu_pipe alu_exec (
    .clk(clk), .rst(rst), .flush(flush), .issue(alu_issue.sink),
    .req(alu_req), .req_tag(alu_req_tag), .req_inst_num(alu_req_inst_num),
    .grant(alu_grant)
  );

  ls_pipe ls_exec (
    .clk(clk), .rst(rst), .flush(flush), .issue(ls_issue.sink),
    .req(ls_req), .req_tag(ls_req_tag), .req_inst_num(ls_req_inst_num),
    .grant(ls_grant), .store_done(store_done), .store_inst_num(store_inst_num)
  );

  cdb_arbiter arb (
    .clk(clk), .rst(rst), .flush(flush),
    .alu_req(alu_req), .alu_tag(alu_req_tag), .alu_inst_num(alu_req_inst_num),
    .ls_req(ls_req), .ls_tag(ls_req_tag), .ls_inst_num(ls_req_inst_num),
    .alu_grant(alu_grant), .ls_grant(ls_grant), .cdb(cdb_bus.source)
  );

  assign cdb_valid    = cdb_bus.valid;
  assign cdb_tag      = cdb_bus.tag;
  assign cdb_inst_num = cdb_bus.inst_num;

endmodule

//--- logic/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  logic               alu_req,
  input  ooo_pkg::tag_t      alu_tag,
  input  ooo_pkg::inst_num_t alu_inst_num,
  input  logic               ls_req,
  input  ooo_pkg::tag_t      ls_tag,
  input  ooo_pkg::inst_num_t ls_inst_num,
  output logic               alu_grant,
  output logic               ls_grant,
  cdb_if.source              cdb
);

  // set when the load/store pipe wins the next contested cycle
  logic ls_first;

  always_comb begin
    alu_grant = alu_req && (!ls_req || !ls_first);
    ls_grant  = ls_req && (!alu_req || ls_first);
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      cdb.valid <= 1'b0;
      ls_first  <= 1'b0;
    end else begin
      cdb.valid <= alu_grant || ls_grant;
      // priority only turns over when both pipes asked
      if (alu_req && ls_req) begin
        ls_first <= !ls_first;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alu_grant) begin
      cdb.tag      <= alu_tag;
      cdb.inst_num <= alu_inst_num;
    end else if (ls_grant) begin
      cdb.tag      <= ls_tag;
      cdb.inst_num <= ls_inst_num;
    end
  end

endmodule

//--- logic/ls_pipe.sv
`timescale 1ns/1ps

module ls_pipe (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  issue_if.sink              issue,
  output logic               req,
  output ooo_pkg::tag_t      req_tag,
  output ooo_pkg::inst_num_t req_inst_num,
  input  logic               grant,
  output logic               store_done,
  output ooo_pkg::inst_num_t store_inst_num
);

  logic [ooo_pkg::LS_LATENCY-1:0] stage_valid;
  logic [ooo_pkg::LS_LATENCY-1:0] stage_free;
  logic [ooo_pkg::LS_LATENCY-1:0] stage_store;
  ooo_pkg::tag_t                  stage_tag  [ooo_pkg::LS_LATENCY];
  ooo_pkg::inst_num_t             stage_inst [ooo_pkg::LS_LATENCY];

  logic last_valid;
  logic last_store;

  assign last_valid = stage_valid[ooo_pkg::LS_LATENCY-1];
  assign last_store = stage_store[ooo_pkg::LS_LATENCY-1];

  // ========================================
  // stall from the back
  // ========================================

  // a store leaves the last stage at once, a load waits for its grant
  always_comb begin
    stage_free[ooo_pkg::LS_LATENCY-1] = !last_valid || last_store || grant;
    for (int i = ooo_pkg::LS_LATENCY - 2; i >= 0; i--) begin
      stage_free[i] = !stage_valid[i] || stage_free[i+1];
    end
  end

  assign issue.accept = stage_free[0];

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      stage_valid <= '0;
    end else begin
      if (stage_free[0]) begin
        stage_valid[0] <= issue.fire;
      end
      for (int i = 1; i < ooo_pkg::LS_LATENCY; i++) begin
        if (stage_free[i]) begin
          stage_valid[i] <= stage_valid[i-1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stage_free[0]) begin
      stage_store[0] <= issue.payload.mem_write;
      stage_tag[0]   <= issue.dest;
      stage_inst[0]  <= issue.inst_num;
    end
    for (int i = 1; i < ooo_pkg::LS_LATENCY; i++) begin
      if (stage_free[i]) begin
        stage_store[i] <= stage_store[i-1];
        stage_tag[i]   <= stage_tag[i-1];
        stage_inst[i]  <= stage_inst[i-1];
      end
    end
  end

  // ========================================
  // completion
  // ========================================

  assign req          = last_valid && !last_store;
  assign req_tag      = stage_tag[ooo_pkg::LS_LATENCY-1];
  assign req_inst_num = stage_inst[ooo_pkg::LS_LATENCY-1];

  // one cycle wide, since a store never stalls in the last stage
  assign store_done     = last_valid && last_store;
  assign store_inst_num = stage_inst[ooo_pkg::LS_LATENCY-1];

endmodule

//--- logic/alu_pipe.sv
`timescale 1ns/1ps

module alu_pipe (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  issue_if.sink              issue,
  output logic               req,
  output ooo_pkg::tag_t      req_tag,
  output ooo_pkg::inst_num_t req_inst_num,
  input  logic               grant
);

  logic [ooo_pkg::ALU_LATENCY-1:0] stage_valid;
  logic [ooo_pkg::ALU_LATENCY-1:0] stage_free;
  ooo_pkg::tag_t                   stage_tag  [ooo_pkg::ALU_LATENCY];
  ooo_pkg::inst_num_t              stage_inst [ooo_pkg::ALU_LATENCY];

  // the last stage is the result register and frees only on a grant
  always_comb begin
    stage_free[ooo_pkg::ALU_LATENCY-1] = !stage_valid[ooo_pkg::ALU_LATENCY-1] || grant;
    for (int i = ooo_pkg::ALU_LATENCY - 2; i >= 0; i--) begin
      stage_free[i] = !stage_valid[i] || stage_free[i+1];
    end
  end

  assign issue.accept = stage_free[0];

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      stage_valid <= '0;
    end else begin
      if (stage_free[0]) begin
        stage_valid[0] <= issue.fire;
      end
      for (int i = 1; i < ooo_pkg::ALU_LATENCY; i++) begin
        if (stage_free[i]) begin
          stage_valid[i] <= stage_valid[i-1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stage_free[0]) begin
      stage_tag[0]  <= issue.dest;
      stage_inst[0] <= issue.inst_num;
    end
    for (int i = 1; i < ooo_pkg::ALU_LATENCY; i++) begin
      if (stage_free[i]) begin
        stage_tag[i]  <= stage_tag[i-1];
        stage_inst[i] <= stage_inst[i-1];
      end
    end
  end

  assign req          = stage_valid[ooo_pkg::ALU_LATENCY-1];
  assign req_tag      = stage_tag[ooo_pkg::ALU_LATENCY-1];
  assign req_inst_num = stage_inst[ooo_pkg::ALU_LATENCY-1];

endmodule

//--- logic/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
  parameter type payload_t = logic
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  logic               dispatch,
  input  ooo_pkg::inst_num_t dispatch_inst_num,
  input  ooo_pkg::tag_t      dispatch_dest,
  input  ooo_pkg::tag_t      src1,
  input  ooo_pkg::tag_t      src2,
  input  logic [1:0]         src_ready,
  input  payload_t           dispatch_payload,
  output logic               full,
  cdb_if.sink                cdb,
  issue_if.source            issue
);

  // ========================================
  // entry storage
  // ========================================

  logic [ooo_pkg::RS_DEPTH-1:0] occupied;
  logic [ooo_pkg::RS_DEPTH-1:0] rdy1;
  logic [ooo_pkg::RS_DEPTH-1:0] rdy2;

  ooo_pkg::tag_t      src1_q    [ooo_pkg::RS_DEPTH];
  ooo_pkg::tag_t      src2_q    [ooo_pkg::RS_DEPTH];
  ooo_pkg::tag_t      dest_q    [ooo_pkg::RS_DEPTH];
  ooo_pkg::inst_num_t inst_q    [ooo_pkg::RS_DEPTH];
  payload_t           payload_q [ooo_pkg::RS_DEPTH];

  ooo_pkg::rs_idx_t alloc_idx;
  logic             alloc_ok;
  logic             do_alloc;
  ooo_pkg::rs_idx_t sel_idx;
  logic             sel_ok;

  // a result on the bus right now counts as ready for the incoming sources
  logic bypass1;
  logic bypass2;

  assign bypass1 = cdb.valid && (src1 == cdb.tag);
  assign bypass2 = cdb.valid && (src2 == cdb.tag);

  assign full     = &occupied;
  assign do_alloc = dispatch && alloc_ok;

  // ========================================
  // allocation and selection
  // ========================================

  // lowest free index wins, so scan from the top down
  always_comb begin
    alloc_ok  = 1'b0;
    alloc_idx = '0;
    for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
      if (!occupied[i]) begin
        alloc_ok  = 1'b1;
        alloc_idx = ooo_pkg::rs_idx_t'(i);
      end
    end
  end

  // lowest index with both sources ready goes next
  always_comb begin
    sel_ok  = 1'b0;
    sel_idx = '0;
    for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
      if (occupied[i] && rdy1[i] && rdy2[i]) begin
        sel_ok  = 1'b1;
        sel_idx = ooo_pkg::rs_idx_t'(i);
      end
    end
  end

  assign issue.fire     = sel_ok && issue.accept;
  assign issue.inst_num = inst_q[sel_idx];
  assign issue.dest     = dest_q[sel_idx];
  assign issue.payload  = payload_q[sel_idx];

  // ========================================
  // control state
  // ========================================

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      occupied <= '0;
      rdy1     <= '0;
      rdy2     <= '0;
    end else begin
      // wakeup of waiting entries
      for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
        if (cdb.valid && occupied[i] && (src1_q[i] == cdb.tag)) begin
          rdy1[i] <= 1'b1;
        end
        if (cdb.valid && occupied[i] && (src2_q[i] == cdb.tag)) begin
          rdy2[i] <= 1'b1;
        end
      end

      // the issued entry is freed at the same edge it leaves
      if (issue.fire) begin
        occupied[sel_idx] <= 1'b0;
      end

      // allocation only ever targets a free entry, never the one issuing
      if (do_alloc) begin
        occupied[alloc_idx] <= 1'b1;
        rdy1[alloc_idx]     <= src_ready[0] || bypass1;
        rdy2[alloc_idx]     <= src_ready[1] || bypass2;
      end
    end
  end

  // ========================================
  // payload capture
  // ========================================

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      src1_q[alloc_idx]    <= src1;
      src2_q[alloc_idx]    <= src2;
      dest_q[alloc_idx]    <= dispatch_dest;
      inst_q[alloc_idx]    <= dispatch_inst_num;
      payload_q[alloc_idx] <= dispatch_payload;
    end
  end

endmodule

//--- logic/issue_if.sv
`timescale 1ns/1ps

// one instruction leaving a station for its execution pipe
interface issue_if #(
  parameter type payload_t = logic
);

  logic               fire;
  logic               accept;
  ooo_pkg::inst_num_t inst_num;
  ooo_pkg::tag_t      dest;
  payload_t           payload;

  // fire may only rise while the pipe holds accept high
  modport source (
    output fire,
    output inst_num,
    output dest,
    output payload,
    input  accept
  );

  modport sink (
    input  fire,
    input  inst_num,
    input  dest,
    input  payload,
    output accept
  );

endinterface

//--- logic/cdb_if.sv
`timescale 1ns/1ps

// one result broadcast on the common data bus
interface cdb_if;

  logic               valid;
  ooo_pkg::tag_t      tag;
  ooo_pkg::inst_num_t inst_num;

  modport source (
    output valid,
    output tag,
    output inst_num
  );

  modport sink (
    input valid,
    input tag,
    input inst_num
  );

endinterface

//--- logic/ooo_pkg.sv
package ooo_pkg;

  // ========================================
  // sizing
  // ========================================

  localparam int RS_DEPTH = 8;
  localparam int RS_IDX_W = 3;

  // pipe depths counted in edges from accept to the cdb request
  localparam int ALU_LATENCY = 1;
  localparam int LS_LATENCY  = 2;

  // ========================================
  // tags and entries
  // ========================================

  typedef logic [7:0]  tag_t;
  typedef logic [31:0] inst_num_t;

  // index of one reservation station entry
  typedef logic [RS_IDX_W-1:0] rs_idx_t;

  // ========================================
  // per-station payloads
  // ========================================

  typedef struct packed {
    logic [3:0]  alu_op;
    logic        alu_src2;
    logic [31:0] immediate;
  } alu_payload_t;

  typedef struct packed {
    logic        mem_read;
    logic        mem_write;
    logic        mem_to_reg;
    logic [2:0]  funct3;
    logic [31:0] immediate;
  } ls_payload_t;

endpackage
